/* common/chart_pkg.sv */
package chart_pkg;

    // Note memory size
    localparam int CHART_LEN = 16;
    localparam int CHART_AW  = 4;

    // One note, all zero is a rest
    typedef struct packed {
        logic       oct_down;
        logic       oct_up;
        logic [6:0] keys;     // One-hot, C in bit 0
    } note_t;

    // Chart load port
    typedef struct packed {
        logic                en;
        logic [CHART_AW-1:0] addr;
        note_t               note;
    } chart_write_t;

    // Player key input
    typedef struct packed {
        note_t note;
        logic  auto_play;
    } play_input_t;

    typedef logic [13:0] score_t;

    // Bit 0 octave shift, bits 7..1 keys C..B
    typedef logic [7:0] led_t;

    // Eight ASCII characters, character 0 in the top byte
    typedef logic [63:0] seg_text_t;

    typedef enum logic [1:0] {
        COUNTING = 2'd0,
        PLAYING  = 2'd1,
        FINISHED = 2'd2
    } play_phase_e;

endpackage

/* hdl/tick_divider.sv */
`timescale 1ns/1ps

module tick_divider #(
    parameter int TICK_DIV = 3
) (
    input  logic prog_clk,
    input  logic rst,
    output logic judge_tick
);
    localparam int CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CW-1:0] div_cnt;

    // Free-running count, one-cycle enable on the wrap
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            div_cnt    <= '0;
            judge_tick <= 1'b0;
        end else begin
            if (div_cnt == CW'(TICK_DIV - 1)) begin
                div_cnt    <= '0;
                judge_tick <= 1'b1;
            end else begin
                div_cnt    <= div_cnt + 1'b1;
                judge_tick <= 1'b0;
            end
        end
    end

endmodule

/* hdl/count_down.sv */
`timescale 1ns/1ps

module count_down import chart_pkg::*; #(
    parameter int COUNT_TICKS = 20
) (
    input  logic        prog_clk,
    input  logic        rst,
    input  logic        judge_tick,
    input  logic        chart_done,
    output play_phase_e phase,
    output logic [1:0]  cnt_digit
);
    localparam int TW = (COUNT_TICKS > 1) ? $clog2(COUNT_TICKS) : 1;

    logic [TW-1:0] tick_cnt;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            phase     <= COUNTING;
            cnt_digit <= 2'd3;
            tick_cnt  <= '0;
        end else begin
            case (phase)
                COUNTING: begin
                    if (judge_tick) begin
                        if (tick_cnt == TW'(COUNT_TICKS - 1)) begin
                            tick_cnt <= '0;
                            // Digit 0 has run its full length, start play
                            if (cnt_digit == 2'd0) begin
                                phase <= PLAYING;
                            end else begin
                                cnt_digit <= cnt_digit - 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                PLAYING: begin
                    if (chart_done) begin
                        phase <= FINISHED;
                    end
                end
                // Held until reset
                default: phase <= FINISHED;
            endcase
        end
    end

endmodule

/* hdl/note_sequencer.sv */
`timescale 1ns/1ps

module note_sequencer import chart_pkg::*; #(
    parameter int STEP_TICKS = 2
) (
    input  logic              prog_clk,
    input  logic              rst,
    input  logic              judge_tick,
    input  play_phase_e       phase,
    input  chart_write_t      chart_wr,
    input  logic [CHART_AW:0] chart_len,
    output note_t             cur_note,
    output logic              step,
    output logic              chart_done
);
    localparam int SW = (STEP_TICKS > 1) ? $clog2(STEP_TICKS) : 1;

    note_t             note_mem [CHART_LEN];
    logic [CHART_AW:0] note_idx;
    logic [SW-1:0]     step_cnt;
    logic              step_now;

    // Chart load, only before play starts
    always_ff @(posedge prog_clk) begin
        if (chart_wr.en && phase == COUNTING) begin
            note_mem[chart_wr.addr] <= chart_wr.note;
        end
    end

    assign step_now = (phase == PLAYING) && judge_tick && (step_cnt == SW'(STEP_TICKS - 1));

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            step_cnt <= '0;
            note_idx <= '0;
            cur_note <= '0;
            step     <= 1'b0;
        end else begin
            step <= step_now;
            // Tick count starts fresh when play begins
            if (phase != PLAYING) begin
                step_cnt <= '0;
            end else if (judge_tick) begin
                if (step_now) begin
                    step_cnt <= '0;
                end else begin
                    step_cnt <= step_cnt + 1'b1;
                end
            end
            if (step_now) begin
                cur_note <= note_mem[note_idx[CHART_AW-1:0]];
                note_idx <= note_idx + 1'b1;
            end
        end
    end

    // An empty chart never ends
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            chart_done <= 1'b0;
        end else begin
            chart_done <= (chart_len != '0) && (note_idx == chart_len);
        end
    end

endmodule

/* score/score_judge.sv */
`timescale 1ns/1ps

module score_judge import chart_pkg::*; (
    input  logic        prog_clk,
    input  logic        rst,
    input  logic        judge_tick,
    input  play_phase_e phase,
    input  play_input_t play_in,
    input  note_t       cur_note,
    output score_t      score
);
    // Older samples, hist_q[0] is last tick's input
    note_t        hist_q [3];
    note_t        hist   [4];
    logic [2:0]   points;
    logic [14:0]  score_sum;
    logic         judge_en;

    assign judge_en = judge_tick && (phase == PLAYING);

    // h0 is the live sample of this tick
    always_comb begin
        hist[0] = play_in.note;
        for (int i = 1; i < 4; i++) begin
            hist[i] = hist_q[i-1];
        end
    end

    // First matching rule wins
    always_comb begin
        if (play_in.auto_play) begin
            points = 3'd4;
        end else if (cur_note == '0) begin
            points = 3'd0;
        end else if (cur_note == hist[0] || cur_note == hist[1]) begin
            points = 3'd4;
        end else if (cur_note == hist[2]) begin
            points = 3'd2;
        end else if (cur_note == hist[3]) begin
            points = 3'd1;
        end else begin
            points = 3'd0;
        end
    end

    assign score_sum = {1'b0, score} + 15'(points);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
            for (int i = 0; i < 3; i++) begin
                hist_q[i] <= '0;
            end
        end else if (judge_en) begin
            for (int i = 0; i < 3; i++) begin
                hist_q[i] <= hist[i];
            end
            // Saturate instead of wrapping
            if (score_sum[14]) begin
                score <= '1;
            end else begin
                score <= score_sum[13:0];
            end
        end
    end

endmodule

/* hdl/note_display.sv */
`timescale 1ns/1ps

module note_display import chart_pkg::*; (
    input  logic      prog_clk,
    input  logic      rst,
    input  note_t     cur_note,
    output led_t      led,
    output seg_text_t seg
);
    // Letters for keys C to B, C in the top byte
    localparam logic [55:0] KEY_LETTERS = "cdefgab";
    localparam seg_text_t   SEG_BLANK   = {8{8'h20}};

    logic       key_onehot;
    logic       note_valid;
    logic [2:0] key_idx;
    logic [7:0] oct_char;
    led_t       led_next;
    seg_text_t  seg_next;

    assign key_onehot = (cur_note.keys != '0) &&
                        ((cur_note.keys & (cur_note.keys - 7'd1)) == '0);
    assign note_valid = key_onehot && !(cur_note.oct_up && cur_note.oct_down);

    // Position of the pressed key
    always_comb begin
        key_idx = 3'd0;
        for (int i = 0; i < 7; i++) begin
            if (cur_note.keys[i]) begin
                key_idx = 3'(i);
            end
        end
    end

    always_comb begin
        led_next    = '0;
        led_next[0] = cur_note.oct_up ^ cur_note.oct_down;
        if (key_onehot) begin
            // C lights bit 7, B lights bit 1
            for (int i = 0; i < 7; i++) begin
                led_next[7-i] = cur_note.keys[i];
            end
        end
    end

    always_comb begin
        if (cur_note.oct_up) begin
            oct_char = "u";
        end else if (cur_note.oct_down) begin
            oct_char = "d";
        end else begin
            oct_char = " ";
        end
        if (note_valid) begin
            seg_next = {KEY_LETTERS[8*(6-key_idx) +: 8], " ", oct_char,
                        8'("1") + 8'(key_idx), "    "};
        end else begin
            seg_next = SEG_BLANK;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            led <= '0;
            seg <= SEG_BLANK;
        end else begin
            led <= led_next;
            seg <= seg_next;
        end
    end

endmodule

/* hdl/chart_player.sv */
`timescale 1ns/1ps

module chart_player import chart_pkg::*; #(
    parameter int TICK_DIV    = 3,
    parameter int COUNT_TICKS = 20,
    parameter int STEP_TICKS  = 2
) (
    input  logic              prog_clk,
    input  logic              rst,
    input  chart_write_t      chart_wr,
    input  logic [CHART_AW:0] chart_len,
    input  play_input_t       play_in,
    output play_phase_e       phase,
    output logic [1:0]        cnt_digit,
    output note_t             cur_note,
    output score_t            score,
    output led_t              led,
    output seg_text_t         seg
);
    logic judge_tick;
    logic chart_done;

    tick_divider #(.TICK_DIV(TICK_DIV)) i_tick_divider (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .judge_tick (judge_tick)
    );

    count_down #(.COUNT_TICKS(COUNT_TICKS)) i_count_down (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .judge_tick (judge_tick),
        .chart_done (chart_done),
        .phase      (phase),
        .cnt_digit  (cnt_digit)
    );

    note_sequencer #(.STEP_TICKS(STEP_TICKS)) i_note_sequencer (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .judge_tick (judge_tick),
        .phase      (phase),
        .chart_wr   (chart_wr),
        .chart_len  (chart_len),
        .cur_note   (cur_note),
        .step       (),
        .chart_done (chart_done)
    );

    score_judge i_score_judge (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .judge_tick (judge_tick),
        .phase      (phase),
        .play_in    (play_in),
        .cur_note   (cur_note),
        .score      (score)
    );

    note_display i_note_display (
        .prog_clk (prog_clk),
        .rst      (rst),
        .cur_note (cur_note),
        .led      (led),
        .seg      (seg)
    );

endmodule

/* verif/tb_chart_player.sv */
`timescale 1ns/1ps

module tb_chart_player import chart_pkg::*; ();

    localparam int        TICK_DIV    = 4;
    localparam int        COUNT_TICKS = 3;
    localparam int        STEP_TICKS  = 2;
    localparam seg_text_t BLANK       = {8{8'h20}};

    logic         prog_clk;
    logic         rst;
    chart_write_t chart_wr;
    logic [CHART_AW:0] chart_len;
    play_input_t  play_in;
    play_phase_e  phase;
    logic [1:0]   cnt_digit;
    note_t        cur_note;
    score_t       score;
    led_t         led;
    seg_text_t    seg;

    // Reference model state
    int          seed;
    int          cyc;
    int          m_edges;
    logic        m_tick;
    play_phase_e m_phase;
    int          m_digit;
    int          m_cnt_ticks;
    int          m_step_ticks;
    logic [4:0]  m_idx;
    note_t       m_note;
    logic        m_done;
    note_t       m_mem [CHART_LEN];
    note_t       m_hist [3];
    int          m_score;
    int          m_play_ticks;
    led_t        m_led;
    seg_text_t   m_seg;

    chart_player #(
        .TICK_DIV    (TICK_DIV),
        .COUNT_TICKS (COUNT_TICKS),
        .STEP_TICKS  (STEP_TICKS)
    ) i_dut (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .chart_wr  (chart_wr),
        .chart_len (chart_len),
        .play_in   (play_in),
        .phase     (phase),
        .cnt_digit (cnt_digit),
        .cur_note  (cur_note),
        .score     (score),
        .led       (led),
        .seg       (seg)
    );

    initial begin
        prog_clk = 1'b0;
        forever #20 prog_clk = ~prog_clk;
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp));
        end
    endtask

    // Key position 0..6 for exactly one pressed key, else -1
    function automatic int key_pos(input note_t n);
        int pos;
        int hits;
        pos  = -1;
        hits = 0;
        for (int i = 0; i < 7; i++) begin
            if (n.keys[i]) begin
                pos  = i;
                hits = hits + 1;
            end
        end
        return (hits == 1) ? pos : -1;
    endfunction

    function automatic led_t led_of(input note_t n);
        led_t l;
        int   pos;
        l   = '0;
        pos = key_pos(n);
        l[0] = (n.oct_up != n.oct_down);
        if (pos >= 0) begin
            l[7-pos] = 1'b1;
        end
        return l;
    endfunction

    function automatic seg_text_t seg_of(input note_t n);
        string      letters;
        int         pos;
        logic [7:0] oct;
        letters = "cdefgab";
        pos     = key_pos(n);
        oct     = n.oct_up ? 8'h75 : (n.oct_down ? 8'h64 : 8'h20);
        if (pos < 0 || (n.oct_up && n.oct_down)) begin
            return BLANK;
        end
        return {8'(letters[pos]), 8'h20, oct, 8'(8'h31 + pos), 32'h20202020};
    endfunction

    // Sooner matching input earns more
    function automatic int points_for(input logic auto_on, input note_t want, input note_t h0,
                                      input note_t h1, input note_t h2, input note_t h3);
        if (auto_on) begin
            return 4;
        end else if (want == '0) begin
            return 0;
        end else if (want == h0 || want == h1) begin
            return 4;
        end else if (want == h2) begin
            return 2;
        end else if (want == h3) begin
            return 1;
        end
        return 0;
    endfunction

    function automatic note_t random_note();
        note_t n;
        int    oct;
        n = 9'($random(seed));
        if ($random(seed) & 1) begin
            oct     = $unsigned($random(seed)) % 3;
            n.keys  = 7'(1 << ($unsigned($random(seed)) % 7));
            n.oct_up   = (oct == 1);
            n.oct_down = (oct == 2);
        end
        return n;
    endfunction

    task automatic clear_model();
        m_edges      = 0;
        m_tick       = 1'b0;
        m_phase      = COUNTING;
        m_digit      = 3;
        m_cnt_ticks  = 0;
        m_step_ticks = 0;
        m_idx        = '0;
        m_note       = '0;
        m_done       = 1'b0;
        m_hist       = '{default: '0};
        m_score      = 0;
        m_play_ticks = 0;
        m_led        = '0;
        m_seg        = BLANK;
    endtask

    // One clock edge with all updates taken from the state before the edge
    task automatic advance_model();
        logic        tick;
        play_phase_e ph;
        note_t       shown;
        int          pts;
        tick  = m_tick;
        ph    = m_phase;
        shown = m_note;
        m_led = led_of(shown);
        m_seg = seg_of(shown);
        if (ph == PLAYING && m_done) begin
            m_phase = FINISHED;
        end
        m_done = (chart_len != 0) && (m_idx == chart_len);
        if (chart_wr.en && ph == COUNTING) begin
            m_mem[chart_wr.addr] = chart_wr.note;
        end
        if (ph == COUNTING && tick) begin
            if (m_cnt_ticks == COUNT_TICKS - 1) begin
                m_cnt_ticks = 0;
                if (m_digit == 0) begin
                    m_phase = PLAYING;
                end else begin
                    m_digit = m_digit - 1;
                end
            end else begin
                m_cnt_ticks = m_cnt_ticks + 1;
            end
        end
        if (ph != PLAYING) begin
            m_step_ticks = 0;
        end else if (tick) begin
            if (m_step_ticks == STEP_TICKS - 1) begin
                m_step_ticks = 0;
                m_note       = m_mem[m_idx[CHART_AW-1:0]];
                m_idx        = m_idx + 1'b1;
            end else begin
                m_step_ticks = m_step_ticks + 1;
            end
        end
        if (ph == PLAYING && tick) begin
            pts = points_for(play_in.auto_play, shown, play_in.note,
                             m_hist[0], m_hist[1], m_hist[2]);
            m_score      = (m_score + pts > 16383) ? 16383 : m_score + pts;
            m_hist[2]    = m_hist[1];
            m_hist[1]    = m_hist[0];
            m_hist[0]    = play_in.note;
            m_play_ticks = m_play_ticks + 1;
        end
        m_edges = m_edges + 1;
        m_tick  = (m_edges % TICK_DIV == 0);
    endtask

    task automatic run_cycle();
        @(posedge prog_clk);
        advance_model();
        cyc = cyc + 1;
        #2;
        check_value(phase, m_phase, "phase");
        check_value(cnt_digit, m_digit, "cnt_digit");
        check_value(cur_note, m_note, "cur_note");
        check_value(score, m_score, "score");
        check_value(led, m_led, "led");
        check_value(seg, m_seg, "seg");
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        clear_model();
        repeat (16) @(posedge prog_clk);
        #2;
        rst = 1'b0;
        cyc = 0;
    endtask

    // Current note, next note pressed early, or random keys
    task automatic drive_play(input logic auto_on);
        int mode;
        mode = $unsigned($random(seed)) % 3;
        play_in.auto_play = auto_on;
        if (mode == 0) begin
            play_in.note = m_note;
        end else if (mode == 1 && m_idx < chart_len) begin
            play_in.note = m_mem[m_idx[CHART_AW-1:0]];
        end else begin
            play_in.note = random_note();
        end
    endtask

    task automatic wait_playing(input logic auto_on);
        int n;
        n = 0;
        while (phase != PLAYING) begin
            drive_play(auto_on);
            run_cycle();
            n = n + 1;
            if (n > 200) begin
                stop_on_error("Timeout: play never started after the countdown");
            end
        end
        // First tick comes TICK_DIV cycles after reset and phase registers one clock later
        check_value(cyc, TICK_DIV * 4 * COUNT_TICKS + 1, "cycles to PLAYING");
    endtask

    initial begin
        int     n;
        note_t  hold_note;
        score_t hold_score;
        seed      = 55958;
        cyc       = 0;
        m_mem     = '{default: '0};
        chart_wr  = '0;
        chart_len = '0;
        play_in   = '0;
        rst       = 1'b1;
        apply_reset();
        check_value(phase, COUNTING, "phase after reset");
        check_value(cnt_digit, 3, "cnt_digit after reset");
        check_value(score, 0, "score after reset");
        check_value(led, 0, "led after reset");
        check_value(seg, BLANK, "seg after reset");

        // First run loads the chart during the countdown
        chart_len = 5'd12;
        for (int i = 0; i < CHART_LEN; i++) begin
            chart_wr.en   = 1'b1;
            chart_wr.addr = CHART_AW'(i);
            chart_wr.note = random_note();
            drive_play(1'b0);
            run_cycle();
        end
        chart_wr = '0;
        wait_playing(1'b0);
        n = 0;
        while (phase != FINISHED) begin
            drive_play(1'b0);
            run_cycle();
            n = n + 1;
            if (n > 400) begin
                stop_on_error("Timeout: chart never finished");
            end
        end
        check_value(cur_note, m_mem[chart_len - 5'd1], "last note played");
        hold_note  = m_note;
        hold_score = score_t'(m_score);
        repeat (40) begin
            drive_play(1'b0);
            run_cycle();
            check_value(cur_note, hold_note, "cur_note after finish");
            check_value(score, hold_score, "score after finish");
        end

        // Second run uses auto play with an empty chart
        apply_reset();
        chart_len = '0;
        wait_playing(1'b1);
        repeat (300) begin
            drive_play(1'b1);
            run_cycle();
            check_value(phase == FINISHED, 0, "phase left PLAYING with empty chart");
        end
        check_value(score, 4 * m_play_ticks, "auto play score");
        $display(">>> PASS");
        $finish;
    end

endmodule

/* list.f */
common/chart_pkg.sv
hdl/tick_divider.sv
hdl/count_down.sv
hdl/note_sequencer.sv
score/score_judge.sv
hdl/note_display.sv
hdl/chart_player.sv
verif/tb_chart_player.sv
